//--- src/cache_geom_pkg.sv
/*
  cache geometry constants and the vector types for address, word,
  line, tag, index and word select
*/
`default_nettype none

package cache_geom_pkg;

  // ----------------------------------------------------------
  // capacity and organisation
  // ----------------------------------------------------------

  localparam int cache_bytes = 256;
  localparam int line_bytes  = 16;
  localparam int num_ways    = 2;
  // sets per way
  localparam int num_sets    = cache_bytes / (line_bytes * num_ways);

  // bus widths
  localparam int addr_bits      = 32;
  localparam int word_bits      = 32;
  localparam int line_bits      = line_bytes * 8;
  localparam int words_per_line = line_bits / word_bits;
  localparam int word_sel_bits  = $clog2(words_per_line);
  localparam int offset_bits    = $clog2(line_bytes);
  localparam int index_bits     = $clog2(num_sets);
  localparam int tag_bits       = addr_bits - index_bits - offset_bits;

  // ----------------------------------------------------------
  // vector types
  // ----------------------------------------------------------

  typedef logic [addr_bits-1:0]     addr_t;
  typedef logic [word_bits-1:0]     word_t;
  typedef logic [line_bits-1:0]     line_t;
  // address bits above index and offset
  typedef logic [tag_bits-1:0]      tag_t;
  typedef logic [index_bits-1:0]    index_t;
  // word within a line
  typedef logic [word_sel_bits-1:0] word_sel_t;

endpackage

`default_nettype wire

//--- src/cache_msg_pkg.sv
/*
  request and response messages for the processor and memory ports,
  and the shared message type
*/
`default_nettype none

package cache_msg_pkg;

  // ----------------------------------------------------------
  // message type
  // ----------------------------------------------------------

  typedef enum logic {
    msg_read  = 1'b0,
    msg_write = 1'b1
  } msg_type_t;

  // ----------------------------------------------------------
  // processor side
  // ----------------------------------------------------------

  // word access, 65 bits
  typedef struct packed {
    msg_type_t             msg_type;
    cache_geom_pkg::addr_t addr;
    cache_geom_pkg::word_t data;
  } cache_req_t;

  // 33 bits, data only meaningful for reads
  typedef struct packed {
    msg_type_t             msg_type;
    cache_geom_pkg::word_t data;
  } cache_resp_t;

  // ----------------------------------------------------------
  // memory side
  // ----------------------------------------------------------

  // line access, addr has a zero offset, 161 bits
  typedef struct packed {
    msg_type_t             msg_type;
    cache_geom_pkg::addr_t addr;
    cache_geom_pkg::line_t data;
  } mem_req_t;

  // 129 bits
  typedef struct packed {
    msg_type_t             msg_type;
    cache_geom_pkg::line_t data;
  } mem_resp_t;

endpackage

`default_nettype wire

//--- src/cache_ctrl.sv
/*
  store control struct, request latch and the cache FSM
  (tag check, data access, eviction, refill, response)
*/
`timescale 1ns/1ps
`default_nettype none

// enables and selects from the controller to both stores
typedef struct packed {
  logic tag_check;     // capture hit way
  logic data_read;
  logic data_write;
  logic refill_write;
  logic mark_dirty;
  logic touch_lru;
  logic addr_sel;      // 1 = victim line, 0 = request line
} store_ctrl_t;

module cache_ctrl
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        cachereq_val,
  input  cache_req_t  cachereq,
  output logic        cachereq_rdy,
  output logic        cacheresp_val,
  input  logic        cacheresp_rdy,
  output logic        memreq_val,
  output msg_type_t   memreq_type,
  input  logic        memreq_rdy,
  input  logic        memresp_val,
  output logic        memresp_rdy,
  input  logic        hit,
  input  logic        victim_dirty,
  output cache_req_t  req,
  output store_ctrl_t ctrl
);

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_read_access,
    st_write_access,
    st_evict_req,
    st_evict_wait,
    st_refill_req,
    st_refill_wait,
    st_refill_update,
    st_wait_resp
  } state_t;

  state_t state, state_next;

  // ----------------------------------------------------------
  // request latch held for the whole transaction
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (cachereq_val && cachereq_rdy) begin
      req <= cachereq;
    end
  end

  // ----------------------------------------------------------
  // state register and transitions
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle:          if (cachereq_val) state_next = st_tag_check;
      st_tag_check: begin
        if (hit) begin
          state_next = (req.msg_type == msg_write) ? st_write_access : st_read_access;
        end else if (victim_dirty) begin
          state_next = st_evict_req;
        end else begin
          state_next = st_refill_req;
        end
      end
      st_read_access:   state_next = st_wait_resp;
      st_write_access:  state_next = st_wait_resp;
      st_evict_req:     if (memreq_rdy) state_next = st_evict_wait;
      // write ack from memory, then fetch the new line
      st_evict_wait:    if (memresp_val) state_next = st_refill_req;
      st_refill_req:    if (memreq_rdy) state_next = st_refill_wait;
      st_refill_wait:   if (memresp_val) state_next = st_refill_update;
      st_refill_update: begin
        state_next = (req.msg_type == msg_write) ? st_write_access : st_read_access;
      end
      st_wait_resp:     if (cacheresp_rdy) state_next = st_idle;
      default:          state_next = st_idle;
    endcase
  end

  // ----------------------------------------------------------
  // outputs decoded from state
  // ----------------------------------------------------------

  assign cachereq_rdy  = (state == st_idle);
  // a hit accepted on edge n is seen high at edge n+3
  assign cacheresp_val = (state == st_wait_resp);
  assign memreq_val    = (state == st_evict_req) || (state == st_refill_req);
  assign memresp_rdy   = (state == st_evict_wait) || (state == st_refill_wait);
  // eviction writes the victim line, refill reads the request line
  assign memreq_type   = (state == st_evict_req) ? msg_write : msg_read;

  always_comb begin
    ctrl = '0;
    case (state)
      st_tag_check:     ctrl.tag_check = 1'b1;
      st_read_access: begin
        ctrl.data_read = 1'b1;
        ctrl.touch_lru = 1'b1;
      end
      st_write_access: begin
        ctrl.data_write = 1'b1;
        ctrl.mark_dirty = 1'b1;
        ctrl.touch_lru  = 1'b1;
      end
      st_evict_req:     ctrl.addr_sel = 1'b1;
      st_evict_wait:    ctrl.addr_sel = 1'b1;
      st_refill_update: ctrl.refill_write = 1'b1;
      default:          ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/cache_tag_store.sv
/*
  tag store: tags with valid and dirty bits per way, LRU bit per set,
  hit detection, victim choice and memory line address
*/
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store
  import cache_geom_pkg::*;
#(
  parameter int num_sets = cache_geom_pkg::num_sets
) (
  input  logic        clk,
  input  logic        reset,
  input  addr_t       req_addr,
  input  store_ctrl_t ctrl,
  output logic        hit,
  output logic        hit_way,
  output logic        victim_way,
  output logic        victim_dirty,
  output addr_t       line_addr
);

  // index width follows the set count, tag takes the rest
  localparam int set_bits = $clog2(num_sets);
  localparam int tag_w    = addr_bits - set_bits - offset_bits;

  logic [set_bits-1:0] idx;
  logic [tag_w-1:0]    req_tag;
  logic [tag_w-1:0]    tags [num_ways][num_sets];
  logic [num_sets-1:0] valid [num_ways];
  logic [num_sets-1:0] dirty [num_ways];
  // way to replace next once both are valid
  logic [num_sets-1:0] lru;
  logic [num_ways-1:0] match;
  // way of the current access
  logic                way_q;

  assign idx     = req_addr[offset_bits +: set_bits];
  assign req_tag = req_addr[addr_bits-1 -: tag_w];

  // ----------------------------------------------------------
  // lookup, combinational from the latched request
  // ----------------------------------------------------------

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      match[w] = valid[w][idx] && (tags[w][idx] == req_tag);
    end
  end

  assign hit     = |match;
  assign hit_way = way_q;

  // invalid way first, else lru
  always_comb begin
    if (!valid[0][idx]) begin
      victim_way = 1'b0;
    end else if (!valid[1][idx]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru[idx];
    end
  end

  assign victim_dirty = valid[victim_way][idx] && dirty[victim_way][idx];

  // write-back goes to the victim's own address
  assign line_addr = ctrl.addr_sel ? {tags[victim_way][idx], idx, {offset_bits{1'b0}}}
                                   : {req_tag, idx, {offset_bits{1'b0}}};

  // ----------------------------------------------------------
  // state updates
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < num_ways; w++) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
      lru   <= '0;
      way_q <= 1'b0;
    end else begin
      // two ways, so the hit way is match[1]
      if (ctrl.tag_check) way_q <= match[1];
      // refilled line is clean, and becomes the access way
      if (ctrl.refill_write) begin
        valid[victim_way][idx] <= 1'b1;
        dirty[victim_way][idx] <= 1'b0;
        way_q                  <= victim_way;
      end
      if (ctrl.mark_dirty) dirty[way_q][idx] <= 1'b1;
      // other way becomes lru
      if (ctrl.touch_lru) lru[idx] <= ~way_q;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.refill_write) begin
      tags[victim_way][idx] <= req_tag;
    end
  end

endmodule

`default_nettype wire

//--- src/cache_data_store.sv
/*
  data store: line array per way, word read and write merge,
  refill line register
*/
`timescale 1ns/1ps
`default_nettype none

module cache_data_store
  import cache_geom_pkg::*;
#(
  parameter int num_sets = cache_geom_pkg::num_sets
) (
  input  logic        clk,
  input  addr_t       req_addr,
  input  word_t       req_data,
  input  logic        way,
  input  store_ctrl_t ctrl,
  input  line_t       refill_line,
  output word_t       read_word,
  output line_t       victim_line
);

  localparam int set_bits = $clog2(num_sets);

  line_t               lines [num_ways][num_sets];
  line_t               refill_q;
  line_t               cur_line;
  logic [set_bits-1:0] idx;
  word_sel_t           sel;

  assign idx = req_addr[offset_bits +: set_bits];
  assign sel = req_addr[offset_bits-1 -: word_sel_bits];

  // line of the selected way, also the write-back data
  assign cur_line    = lines[way][idx];
  assign victim_line = cur_line;

  // ----------------------------------------------------------
  // memory response capture
  // ----------------------------------------------------------

  // taken every cycle, holds the line from the transfer edge
  // through the refill update state
  always_ff @(posedge clk) begin
    refill_q <= refill_line;
  end

  // ----------------------------------------------------------
  // array access
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.data_read) begin
      read_word <= cur_line[sel*word_bits +: word_bits];
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.refill_write) begin
      lines[way][idx] <= refill_q;
    end else if (ctrl.data_write) begin
      // merge one word in place
      lines[way][idx][sel*word_bits +: word_bits] <= req_data;
    end
  end

endmodule

`default_nettype wire

//--- src/blocking_cache.sv
/*
  two-way blocking write-back cache, top level
  controller, tag store and data store on val/rdy ports
*/
`timescale 1ns/1ps
`default_nettype none

module blocking_cache
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
#(
  parameter int num_sets = cache_geom_pkg::num_sets
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        cachereq_val,
  output logic        cachereq_rdy,
  input  cache_req_t  cachereq,
  output logic        cacheresp_val,
  input  logic        cacheresp_rdy,
  output cache_resp_t cacheresp,
  output logic        memreq_val,
  input  logic        memreq_rdy,
  output mem_req_t    memreq,
  input  logic        memresp_val,
  output logic        memresp_rdy,
  input  mem_resp_t   memresp
);

  store_ctrl_t ctrl;
  cache_req_t  req;
  msg_type_t   memreq_type;
  logic        hit;
  logic        hit_way;
  logic        victim_way;
  logic        victim_dirty;
  logic        data_way;
  addr_t       line_addr;
  word_t       read_word;
  line_t       victim_line;

  cache_ctrl cache_ctrl_i (
    .clk, .reset,
    .cachereq_val, .cachereq, .cachereq_rdy,
    .cacheresp_val, .cacheresp_rdy,
    .memreq_val, .memreq_type, .memreq_rdy,
    .memresp_val, .memresp_rdy,
    .hit, .victim_dirty,
    .req, .ctrl
  );

  cache_tag_store #(.num_sets(num_sets)) cache_tag_store_i (
    .clk, .reset,
    .req_addr(req.addr),
    .ctrl,
    .hit, .hit_way, .victim_way, .victim_dirty,
    .line_addr
  );

  // victim way during eviction and refill update, else the hit way
  assign data_way = (ctrl.addr_sel || ctrl.refill_write) ? victim_way : hit_way;

  cache_data_store #(.num_sets(num_sets)) cache_data_store_i (
    .clk,
    .req_addr(req.addr),
    .req_data(req.data),
    .way(data_way),
    .ctrl,
    .refill_line(memresp.data),
    .read_word, .victim_line
  );

  // ----------------------------------------------------------
  // port messages
  // ----------------------------------------------------------

  assign cacheresp.msg_type = req.msg_type;
  assign cacheresp.data     = read_word;

  // refill requests carry the victim line as unused data
  assign memreq.msg_type = memreq_type;
  assign memreq.addr     = line_addr;
  assign memreq.data     = victim_line;

endmodule

`default_nettype wire

//--- bench/tb_blocking_cache.sv
/*
  testbench for the blocking cache: clock, reset, memory model with
  random stalls, directed and random requests, assertions, watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module tb_blocking_cache
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
;

  localparam int clk_period     = 8;
  localparam int num_directed   = 13;
  localparam int num_random     = 60;
  localparam int total_requests = num_directed + num_random;
  localparam logic [31:0] seed  = 32'h29899d4c;

  logic        clk;
  logic        reset;
  logic        cachereq_val;
  logic        cachereq_rdy;
  cache_req_t  cachereq;
  logic        cacheresp_val;
  logic        cacheresp_rdy;
  cache_resp_t cacheresp;
  logic        memreq_val;
  logic        memreq_rdy;
  mem_req_t    memreq;
  logic        memresp_val;
  logic        memresp_rdy;
  mem_resp_t   memresp;

  // written-back memory lines by line address
  line_t       mem_lines [addr_t];
  // expected contents per word address
  word_t       ref_mem [addr_t];
  int          mem_reads;
  int          mem_writes;
  addr_t       last_read_addr;
  int          resp_stalls;
  int          memreq_stalls;
  logic [31:0] mem_rand;
  logic [31:0] proc_rand;

  blocking_cache blocking_cache_i (
    .clk, .reset,
    .cachereq_val, .cachereq_rdy, .cachereq,
    .cacheresp_val, .cacheresp_rdy, .cacheresp,
    .memreq_val, .memreq_rdy, .memreq,
    .memresp_val, .memresp_rdy, .memresp
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // untouched memory word is its address xor a constant
  function automatic word_t fill_word(input addr_t a);
    return a ^ 32'h5a5a_c3c3;
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input index_t set,
                                      input word_sel_t word);
    return {tag, set, word, 2'b00};
  endfunction

  function automatic addr_t line_of(input addr_t a);
    return a & ~addr_t'(line_bytes - 1);
  endfunction

  function automatic word_t expected_word(input addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  // word 0 sits in the low bits of a line
  function automatic line_t line_at(input addr_t la);
    line_t l;
    if (mem_lines.exists(la)) return mem_lines[la];
    for (int w = 0; w < words_per_line; w++) begin
      l[w*word_bits +: word_bits] = fill_word(la + addr_t'(4 * w));
    end
    return l;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string what);
    abort_run($sformatf("FAILED %0t: %s", $time, what));
  endtask

  // ----------------------------------------------------------
  // back-pressure rules
  // ----------------------------------------------------------

  resp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp))
    else report_mismatch("cacheresp dropped or changed while stalled");

  req_blocked: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |-> !cachereq_rdy)
    else report_mismatch("cachereq_rdy high while a response is pending");

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq))
    else report_mismatch("memreq dropped or changed while stalled");

  // ----------------------------------------------------------
  // memory model
  // ----------------------------------------------------------

  task automatic serve_memory();
    mem_req_t m;
    line_t    l;
    int       stall;
    m = memreq;
    assert (m.addr[offset_bits-1:0] == '0)
      else report_mismatch($sformatf("memreq address %h not line aligned", m.addr));
    mem_rand = lcg_step(mem_rand);
    stall = int'(mem_rand[17:16]);
    if (stall > 0) memreq_stalls++;
    repeat (stall) @(negedge clk);
    // transfer on the next rising edge
    memreq_rdy = 1'b1;
    @(negedge clk);
    memreq_rdy = 1'b0;
    if (m.msg_type == msg_write) begin
      mem_lines[m.addr] = m.data;
      mem_writes++;
    end else begin
      mem_reads++;
      last_read_addr = m.addr;
    end
    l = line_at(m.addr);
    mem_rand = lcg_step(mem_rand);
    repeat (int'(mem_rand[20:18]) % 5) @(negedge clk);
    assert (memresp_rdy) else report_mismatch("memresp_rdy low after a memory request");
    memresp     = '{msg_type: m.msg_type, data: l};
    memresp_val = 1'b1;
    @(negedge clk);
    memresp_val = 1'b0;
  endtask

  initial begin : memory_model
    mem_rand    = seed;
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp     = '0;
    forever begin
      @(negedge clk);
      if (!reset && memreq_val) serve_memory();
    end
  end

  // ----------------------------------------------------------
  // processor side
  // ----------------------------------------------------------

  // runs one request and its response between falling edges
  task automatic access(input msg_type_t t, input addr_t a, input word_t d,
                        output int latency);
    cache_resp_t resp;
    int          stall;
    cachereq     = '{msg_type: t, addr: a, data: d};
    cachereq_val = 1'b1;
    while (!cachereq_rdy) @(negedge clk);
    @(negedge clk);
    cachereq_val = 1'b0;
    latency = 1;
    while (!cacheresp_val) begin
      @(negedge clk);
      latency++;
    end
    resp = cacheresp;
    proc_rand = lcg_step(proc_rand);
    stall = int'(proc_rand[19:18]);
    if (stall > 0) resp_stalls++;
    repeat (stall) @(negedge clk);
    cacheresp_rdy = 1'b1;
    @(negedge clk);
    cacheresp_rdy = 1'b0;
    assert (resp.msg_type == t) else report_mismatch("response type differs from request");
    if (t == msg_read) begin
      assert (resp.data == expected_word(a))
        else report_mismatch($sformatf("read %h gave %h, expected %h",
                                       a, resp.data, expected_word(a)));
    end else begin
      ref_mem[a] = d;
    end
  endtask

  initial begin : stimulus
    int    lat;
    int    i;
    int    reads_before;
    int    writes_before;
    addr_t a;
    addr_t b;
    addr_t c;
    word_t d;
    line_t l;
    logic [31:0] r;
    proc_rand     = lcg_step(seed);
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq      = '0;
    cacheresp_rdy = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    assert (cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy)
      else report_mismatch("ports not idle after reset");

    // untouched line needs exactly one refill
    a = make_addr(25'h100, 3'd3, 2'd1);
    reads_before  = mem_reads;
    writes_before = mem_writes;
    access(msg_read, a, '0, lat);
    assert (mem_reads == reads_before + 1 && mem_writes == writes_before)
      else report_mismatch("cold read did not issue exactly one memory read");
    assert (last_read_addr == line_of(a))
      else report_mismatch($sformatf("refill address %h, expected %h",
                                     last_read_addr, line_of(a)));

    // resident line hits in three cycles with memory idle
    reads_before = mem_reads;
    access(msg_read, a, '0, lat);
    assert (lat == 3) else report_mismatch($sformatf("hit latency %0d, expected 3", lat));
    assert (mem_reads == reads_before && mem_writes == writes_before)
      else report_mismatch("memory request during a hit");

    // write, read back, then two conflicting tags push the dirty line out
    d = 32'hcafe_0001;
    access(msg_write, a, d, lat);
    access(msg_read, a, '0, lat);
    b = make_addr(25'h200, 3'd3, 2'd0);
    c = make_addr(25'h300, 3'd3, 2'd2);
    access(msg_read, b, '0, lat);
    writes_before = mem_writes;
    access(msg_read, c, '0, lat);
    assert (mem_writes == writes_before + 1)
      else report_mismatch("dirty line was not written back");
    assert (mem_lines.exists(line_of(a))) else report_mismatch("write-back line missing");
    l = mem_lines[line_of(a)];
    assert (l[a[3:2]*word_bits +: word_bits] == d)
      else report_mismatch("write-back line lacks the written word");
    access(msg_read, a, '0, lat);

    // after a, b, a the new tag c must replace b
    a = make_addr(25'h0a1, 3'd5, 2'd0);
    b = make_addr(25'h0b2, 3'd5, 2'd1);
    c = make_addr(25'h0c3, 3'd5, 2'd3);
    access(msg_read, a, '0, lat);
    access(msg_read, b, '0, lat);
    access(msg_read, a, '0, lat);
    access(msg_read, c, '0, lat);
    reads_before  = mem_reads;
    writes_before = mem_writes;
    access(msg_read, a, '0, lat);
    assert (mem_reads == reads_before && mem_writes == writes_before)
      else report_mismatch("recently used line was evicted");
    access(msg_read, b, '0, lat);
    assert (mem_reads == reads_before + 1)
      else report_mismatch("least recently used line was not evicted");

    // random mix over four tags and every set
    for (i = 0; i < num_random; i++) begin
      proc_rand = lcg_step(proc_rand);
      r = proc_rand;
      a = make_addr(tag_t'(r[31:30]) + 25'h40, index_t'(r[29:27]), word_sel_t'(r[26:25]));
      proc_rand = lcg_step(proc_rand);
      access(r[24] ? msg_write : msg_read, a, proc_rand, lat);
    end

    if (resp_stalls > 0 && memreq_stalls > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("back-pressure was never applied on cacheresp or memreq");
    end
  end

  // each request gets a generous cycle budget
  initial begin : watchdog
    #(clk_period * 200 * total_requests);
    abort_run("timeout: the cache did not finish all requests in time");
  end

endmodule

`default_nettype wire

//--- sources.f
src/cache_geom_pkg.sv
src/cache_msg_pkg.sv
src/cache_ctrl.sv
src/cache_tag_store.sv
src/cache_data_store.sv
src/blocking_cache.sv
bench/tb_blocking_cache.sv

//--- Bender.yml
package:
  name: blocking_cache

sources:
  - src/cache_geom_pkg.sv
  - src/cache_msg_pkg.sv
  - src/cache_ctrl.sv
  - src/cache_tag_store.sv
  - src/cache_data_store.sv
  - src/blocking_cache.sv
  - target: test
    files:
      - bench/tb_blocking_cache.sv
